/* rtl/fw_config.svh */
// fifo depths, watchdog half period and identity values of the firewall shell
`ifndef FW_CONFIG_SVH
`define FW_CONFIG_SVH

// store and forward depths, powers of two
`define FW_DATA_DEPTH     64
`define FW_VERDICT_DEPTH  64

// cycles per watchdog half period, short for simulation
`define FW_WDOG_HALF      64

// identity words reported to the shell
`define FW_VENDOR_ID        24'h0002c9
`define FW_PRODUCT_ID       16'd4
`define FW_PRODUCT_VERSION  16'd1
`define FW_CAPS             32'd2

`endif

/* rtl/fw_stream_pkg.sv */
// stream width typedefs and the beat struct of the packet path
`default_nettype none

package fw_stream_pkg;

  // 32 byte beat
  typedef logic [255:0] tdata_t;
  typedef logic [31:0]  tkeep_t;   // one enable per byte

  // bit 0 holds the verdict on the first beat
  typedef logic [11:0]  tuser_t;

  typedef logic [2:0]   tid_t;

  // 304 bits in all
  typedef struct packed {
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;
    tuser_t tuser;
    tid_t   tid;
  } beat_t;

endpackage

`default_nettype wire

/* rtl/fw_shell_pkg.sv */
// identity typedefs, watchdog counter type and the packet position enum
`default_nettype none

package fw_shell_pkg;

  typedef logic [23:0] vendor_id_t;   // ieee oui
  typedef logic [15:0] product_id_t;
  typedef logic [15:0] version_t;
  typedef logic [31:0] caps_t;

  typedef logic [15:0] wdog_cnt_t;

  // where the output stream stands within a packet
  typedef enum logic {
    POS_HEAD,
    POS_BODY
  } pkt_pos_e;

endpackage

`default_nettype wire

/* rtl/classify_decode.sv */
// byte order conversion to and from the classifier, tuple request generation
`timescale 1ns/10ps
`default_nettype none

module classify_decode (
  input  fw_stream_pkg::beat_t nwp_in,
  input  logic                 nwp_in_vld,
  output logic                 nwp_in_rdy,
  output fw_stream_pkg::beat_t cls_in,
  output logic                 cls_in_vld,
  input  logic                 cls_in_rdy,
  output logic                 tuple_req,
  input  fw_stream_pkg::beat_t cls_out,
  output fw_stream_pkg::beat_t cls_out_conv
);

  localparam int NBYTES = $bits(fw_stream_pkg::tkeep_t);

  // mirror data bytes and keep bits, the rest of the beat untouched
  function automatic fw_stream_pkg::beat_t flip(input fw_stream_pkg::beat_t b);
    fw_stream_pkg::beat_t r;
    r = b;
    for (int i = 0; i < NBYTES; i++) begin
      r.tdata[8*i +: 8] = b.tdata[8*(NBYTES-1-i) +: 8];
      r.tkeep[i]        = b.tkeep[NBYTES-1-i];
    end
    return r;
  endfunction

  // inbound, classifier expects the opposite byte order
  assign cls_in     = flip(nwp_in);
  assign cls_in_vld = nwp_in_vld;
  assign nwp_in_rdy = cls_in_rdy;

  // one pulse per packet, on the accepted last beat
  assign tuple_req = nwp_in_vld & cls_in_rdy & nwp_in.tlast;

  // return path back to shell order
  always_comb begin
    cls_out_conv       = flip(cls_out);
    cls_out_conv.tuser = '0;
    cls_out_conv.tid   = '0;   // host side wants a clean id
  end

endmodule

`default_nettype wire

/* rtl/frame_fifo.sv */
// synchronous circular buffer fifo for beats and verdicts
`timescale 1ns/10ps
`default_nettype none

module frame_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 64   // power of two
) (
  input  logic             mlx2sbu_clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  output logic             full,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             wr_ok;
  logic             rd_ok;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);

  // writes while full and reads while empty are dropped
  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  // head of queue shows without a read request
  assign dout = mem[rd_ptr];

  always_ff @(posedge mlx2sbu_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge mlx2sbu_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/verdict_merge.sv */
// first beat tracking and verdict insertion into tuser toward the host port
`timescale 1ns/10ps
`default_nettype none

module verdict_merge (
  input  logic                 mlx2sbu_clk,
  input  logic                 rst_n,
  input  fw_stream_pkg::beat_t beat,
  input  logic                 beat_empty,
  output logic                 beat_rd,
  input  logic                 verdict,
  input  logic                 verdict_empty,
  output logic                 verdict_rd,
  output fw_stream_pkg::beat_t cxp_out,
  output logic                 cxp_out_vld,
  input  logic                 cxp_out_rdy
);

  fw_shell_pkg::pkt_pos_e pos;
  logic                   head;
  logic                   xfer;

  assign head = (pos == fw_shell_pkg::POS_HEAD);

  // head beat waits for its verdict
  assign cxp_out_vld = ~beat_empty & (~head | ~verdict_empty);
  assign xfer        = cxp_out_vld & cxp_out_rdy;

  assign beat_rd    = xfer;
  assign verdict_rd = xfer & head;   // one verdict per packet

  always_comb begin
    cxp_out          = beat;
    cxp_out.tuser[0] = beat.tuser[0] | (head & verdict);
  end

  always_ff @(posedge mlx2sbu_clk) begin
    if (!rst_n) begin
      pos <= fw_shell_pkg::POS_HEAD;
    end else if (xfer) begin
      case (pos)
        fw_shell_pkg::POS_HEAD: begin
          // single beat packet stays in head
          if (!beat.tlast) begin
            pos <= fw_shell_pkg::POS_BODY;
          end
        end
        fw_shell_pkg::POS_BODY: begin
          if (beat.tlast) begin
            pos <= fw_shell_pkg::POS_HEAD;
          end
        end
        default: pos <= fw_shell_pkg::POS_HEAD;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/shell_watchdog.sv */
// free running counter that toggles the shell watchdog line
`timescale 1ns/10ps
`default_nettype none

`include "fw_config.svh"

module shell_watchdog (
  input  logic mlx2sbu_clk,
  input  logic rst_n,
  output logic watchdog
);

  localparam fw_shell_pkg::wdog_cnt_t LAST = fw_shell_pkg::wdog_cnt_t'(`FW_WDOG_HALF - 1);

  fw_shell_pkg::wdog_cnt_t cnt;

  always_ff @(posedge mlx2sbu_clk) begin
    if (!rst_n) begin
      cnt      <= '0;
      watchdog <= 1'b0;
    end else if (cnt == LAST) begin
      cnt      <= '0;
      watchdog <= ~watchdog;   // shell wants a steady toggle
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/fw_top.sv */
// firewall packet path top with classifier ports, watchdog and identity words
`timescale 1ns/10ps
`default_nettype none

`include "fw_config.svh"

module fw_top (
  input  logic                      mlx2sbu_clk,
  input  logic                      rst_n,

  // from network port
  input  fw_stream_pkg::beat_t      nwp_in,
  input  logic                      nwp_in_vld,
  output logic                      nwp_in_rdy,

  // to classifier
  output fw_stream_pkg::beat_t      cls_in,
  output logic                      cls_in_vld,
  input  logic                      cls_in_rdy,
  output logic                      tuple_req,

  // back from classifier
  input  fw_stream_pkg::beat_t      cls_out,
  input  logic                      cls_out_vld,
  output logic                      cls_out_rdy,
  input  logic                      verdict,
  input  logic                      verdict_vld,
  output logic                      verdict_rdy,

  // toward host port
  output fw_stream_pkg::beat_t      cxp_out,
  output logic                      cxp_out_vld,
  input  logic                      cxp_out_rdy,

  output logic                      watchdog,
  output fw_shell_pkg::vendor_id_t  vendor_id,
  output fw_shell_pkg::product_id_t product_id,
  output fw_shell_pkg::version_t    product_version,
  output fw_shell_pkg::caps_t       caps
);

  localparam int BEAT_W = $bits(fw_stream_pkg::beat_t);

  fw_stream_pkg::beat_t cls_out_conv;
  fw_stream_pkg::beat_t fifo_beat;
  logic                 data_full;
  logic                 data_empty;
  logic                 data_rd;
  logic                 verdict_full;
  logic                 verdict_empty;
  logic                 verdict_rd;
  logic                 verdict_head;

  // identity
  assign vendor_id       = `FW_VENDOR_ID;
  assign product_id      = `FW_PRODUCT_ID;
  assign product_version = `FW_PRODUCT_VERSION;
  assign caps            = `FW_CAPS;

  classify_decode u_decode (
    .nwp_in       (nwp_in),
    .nwp_in_vld   (nwp_in_vld),
    .nwp_in_rdy   (nwp_in_rdy),
    .cls_in       (cls_in),
    .cls_in_vld   (cls_in_vld),
    .cls_in_rdy   (cls_in_rdy),
    .tuple_req    (tuple_req),
    .cls_out      (cls_out),
    .cls_out_conv (cls_out_conv)
  );

  assign cls_out_rdy = ~data_full;
  assign verdict_rdy = ~verdict_full;   // strobes while full are lost

  frame_fifo #(
    .WIDTH (BEAT_W),
    .DEPTH (`FW_DATA_DEPTH)
  ) u_data_fifo (
    .mlx2sbu_clk (mlx2sbu_clk),
    .rst_n       (rst_n),
    .wr_en       (cls_out_vld),
    .din         (cls_out_conv),
    .full        (data_full),
    .rd_en       (data_rd),
    .dout        (fifo_beat),
    .empty       (data_empty)
  );

  frame_fifo #(
    .WIDTH (1),
    .DEPTH (`FW_VERDICT_DEPTH)
  ) u_verdict_fifo (
    .mlx2sbu_clk (mlx2sbu_clk),
    .rst_n       (rst_n),
    .wr_en       (verdict_vld),
    .din         (verdict),
    .full        (verdict_full),
    .rd_en       (verdict_rd),
    .dout        (verdict_head),
    .empty       (verdict_empty)
  );

  // sync data with verdicts
  verdict_merge u_merge (
    .mlx2sbu_clk   (mlx2sbu_clk),
    .rst_n         (rst_n),
    .beat          (fifo_beat),
    .beat_empty    (data_empty),
    .beat_rd       (data_rd),
    .verdict       (verdict_head),
    .verdict_empty (verdict_empty),
    .verdict_rd    (verdict_rd),
    .cxp_out       (cxp_out),
    .cxp_out_vld   (cxp_out_vld),
    .cxp_out_rdy   (cxp_out_rdy)
  );

  shell_watchdog u_watchdog (
    .mlx2sbu_clk (mlx2sbu_clk),
    .rst_n       (rst_n),
    .watchdog    (watchdog)
  );

endmodule

`default_nettype wire

/* testbench/fw_assert.sv */
// bound assertions on host port stalls, verdict strobes and head beat holdback
`timescale 1ns/10ps
`default_nettype none

module fw_assert (
  input logic                 mlx2sbu_clk,
  input logic                 rst_n,
  input fw_stream_pkg::beat_t cxp_out,
  input logic                 cxp_out_vld,
  input logic                 cxp_out_rdy,
  input logic                 verdict_vld,
  input logic                 verdict_rdy,
  input logic                 verdict_empty
);

  logic in_body;   // own view of the packet position on cxp_out

  always_ff @(posedge mlx2sbu_clk) begin
    if (!rst_n) begin
      in_body <= 1'b0;
    end else if (cxp_out_vld && cxp_out_rdy) begin
      in_body <= !cxp_out.tlast;
    end
  end

  a_stall_hold: assert property (@(posedge mlx2sbu_clk) disable iff (!rst_n)
    cxp_out_vld && !cxp_out_rdy |=> cxp_out_vld && $stable(cxp_out))
    else $error("cxp_out dropped or changed while stalled");

  // a strobe into a full verdict fifo is lost
  a_verdict_room: assert property (@(posedge mlx2sbu_clk) disable iff (!rst_n)
    verdict_vld |-> verdict_rdy)
    else $error("verdict strobe while verdict fifo full");

  a_head_verdict: assert property (@(posedge mlx2sbu_clk) disable iff (!rst_n)
    cxp_out_vld && !in_body |-> !verdict_empty)
    else $error("head beat offered without a verdict");

endmodule

bind fw_top fw_assert u_assert (
  .mlx2sbu_clk   (mlx2sbu_clk),
  .rst_n         (rst_n),
  .cxp_out       (cxp_out),
  .cxp_out_vld   (cxp_out_vld),
  .cxp_out_rdy   (cxp_out_rdy),
  .verdict_vld   (verdict_vld),
  .verdict_rdy   (verdict_rdy),
  .verdict_empty (verdict_empty)
);

`default_nettype wire

/* testbench/fw_tb.sv */
// testbench for the firewall packet path with classifier model, scoreboard and timeout
`timescale 1ns/10ps
`default_nettype none

`include "fw_config.svh"

module fw_tb;

  localparam int NPKT = 10;
  localparam int SEED = 32'h2498_47bb;

  typedef struct packed {
    logic [7:0]            beats;
    fw_stream_pkg::tkeep_t last_keep;
    logic                  verdict;
  } pkt_t;

  // beat count, keep of the last beat, verdict
  pkt_t pkt_table [NPKT] = '{
    '{8'd1, 32'h0000_000f, 1'b1},
    '{8'd3, 32'hffff_ffff, 1'b0},
    '{8'd2, 32'h0000_0001, 1'b1},
    '{8'd5, 32'h00ff_ffff, 1'b1},
    '{8'd1, 32'h0000_ffff, 1'b0},
    '{8'd4, 32'h7fff_ffff, 1'b0},
    '{8'd1, 32'h0000_0003, 1'b1},
    '{8'd2, 32'h0fff_ffff, 1'b0},
    '{8'd6, 32'h0000_00ff, 1'b1},
    '{8'd1, 32'h0001_ffff, 1'b0}
  };

  logic                      mlx2sbu_clk;
  logic                      rst_n;
  fw_stream_pkg::beat_t      nwp_in;
  logic                      nwp_in_vld;
  logic                      nwp_in_rdy;
  fw_stream_pkg::beat_t      cls_in;
  logic                      cls_in_vld;
  logic                      cls_in_rdy;
  logic                      tuple_req;
  fw_stream_pkg::beat_t      cls_out;
  logic                      cls_out_vld;
  logic                      cls_out_rdy;
  logic                      verdict;
  logic                      verdict_vld;
  logic                      verdict_rdy;
  fw_stream_pkg::beat_t      cxp_out;
  logic                      cxp_out_vld;
  logic                      cxp_out_rdy;
  logic                      watchdog;
  fw_shell_pkg::vendor_id_t  vendor_id;
  fw_shell_pkg::product_id_t product_id;
  fw_shell_pkg::version_t    product_version;
  fw_shell_pkg::caps_t       caps;

  fw_stream_pkg::beat_t src_q [$];   // beats as sent on nwp_in
  fw_stream_pkg::beat_t out_q [$];   // expected on cxp_out
  int                   out_pkt [$];
  int                   in_idx;
  int                   out_idx;
  int                   verdicts_pulsed;
  int                   wd_edges;

  fw_top i_dut (
    .mlx2sbu_clk     (mlx2sbu_clk),
    .rst_n           (rst_n),
    .nwp_in          (nwp_in),
    .nwp_in_vld      (nwp_in_vld),
    .nwp_in_rdy      (nwp_in_rdy),
    .cls_in          (cls_in),
    .cls_in_vld      (cls_in_vld),
    .cls_in_rdy      (cls_in_rdy),
    .tuple_req       (tuple_req),
    .cls_out         (cls_out),
    .cls_out_vld     (cls_out_vld),
    .cls_out_rdy     (cls_out_rdy),
    .verdict         (verdict),
    .verdict_vld     (verdict_vld),
    .verdict_rdy     (verdict_rdy),
    .cxp_out         (cxp_out),
    .cxp_out_vld     (cxp_out_vld),
    .cxp_out_rdy     (cxp_out_rdy),
    .watchdog        (watchdog),
    .vendor_id       (vendor_id),
    .product_id      (product_id),
    .product_version (product_version),
    .caps            (caps)
  );

  initial mlx2sbu_clk = 1'b0;
  always #5 mlx2sbu_clk = ~mlx2sbu_clk;

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_beat(input string what, input fw_stream_pkg::beat_t got,
                            input fw_stream_pkg::beat_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_id(input fw_shell_pkg::vendor_id_t vid,
                          input fw_shell_pkg::product_id_t pid,
                          input fw_shell_pkg::version_t ver, input fw_shell_pkg::caps_t cap);
    if (vid !== `FW_VENDOR_ID || pid !== `FW_PRODUCT_ID ||
        ver !== `FW_PRODUCT_VERSION || cap !== `FW_CAPS) begin
      $display("** Error at %0t: identity words %h %h %h %h differ from config",
               $time, vid, pid, ver, cap);
      stop_with_failure();
    end
  endtask

  function automatic int total_beats();
    int n;
    n = 0;
    for (int p = 0; p < NPKT; p++) n += int'(pkt_table[p].beats);
    return n;
  endfunction

  // random payload per table entry, expected host beats alongside
  function automatic void build_stimulus();
    fw_stream_pkg::beat_t b;
    fw_stream_pkg::beat_t e;
    for (int p = 0; p < NPKT; p++) begin
      for (int k = 0; k < int'(pkt_table[p].beats); k++) begin
        for (int w = 0; w < 8; w++) b.tdata[32*w +: 32] = $urandom;
        b.tlast = (k == int'(pkt_table[p].beats) - 1);
        b.tkeep = b.tlast ? pkt_table[p].last_keep : '1;
        b.tuser = 12'($urandom);
        b.tid   = 3'($urandom);
        e          = b;
        e.tid      = '0;
        e.tuser    = '0;
        e.tuser[0] = (k == 0) && pkt_table[p].verdict;
        src_q.push_back(b);
        out_q.push_back(e);
        out_pkt.push_back(p);
      end
    end
  endfunction

  task automatic send_beat(input fw_stream_pkg::beat_t b);
    nwp_in     = b;
    nwp_in_vld = 1'b1;
    @(posedge mlx2sbu_clk);
    while (!nwp_in_rdy) @(posedge mlx2sbu_clk);
    #1;
    nwp_in_vld = 1'b0;
  endtask

  initial begin : main_seq
    rst_n      = 1'b0;
    nwp_in     = '0;
    nwp_in_vld = 1'b0;
    void'($urandom(SEED));
    build_stimulus();
    repeat (2) @(posedge mlx2sbu_clk);
    #1 rst_n = 1'b1;
    foreach (src_q[i]) send_beat(src_q[i]);
    while (out_idx < out_q.size() || wd_edges < 3 * `FW_WDOG_HALF) @(posedge mlx2sbu_clk);
    @(negedge mlx2sbu_clk);
    check_bit("all inbound beats seen", in_idx == src_q.size(), 1'b1);
    check_bit("cxp_out_vld when drained", cxp_out_vld, 1'b0);
    check_id(vendor_id, product_id, product_version, caps);
    $display("All tests passed");
    $finish;
  end

  // echoes cls_in onto cls_out, verdict once the packet is back
  initial begin : classifier_model
    fw_stream_pkg::beat_t ret_q [$];
    fw_stream_pkg::beat_t in_beat;
    logic                 pend_q [$];
    logic                 in_fire;
    logic                 out_fire;
    logic                 out_last;
    int                   ret_pkt;
    cls_in_rdy  = 1'b0;
    cls_out     = '0;
    cls_out_vld = 1'b0;
    verdict     = 1'b0;
    verdict_vld = 1'b0;
    ret_pkt     = 0;
    @(posedge rst_n);
    forever begin
      @(negedge mlx2sbu_clk);
      in_fire  = cls_in_vld && cls_in_rdy;
      in_beat  = cls_in;
      out_fire = cls_out_vld && cls_out_rdy;
      out_last = cls_out.tlast;
      @(posedge mlx2sbu_clk);
      #1;
      if (in_fire) ret_q.push_back(in_beat);
      if (out_fire) begin
        void'(ret_q.pop_front());
        if (out_last) begin
          pend_q.push_back(pkt_table[ret_pkt].verdict);
          ret_pkt++;
        end
      end
      verdict_vld = 1'b0;
      if (pend_q.size() > 0 && verdict_rdy) begin
        verdict     = pend_q.pop_front();
        verdict_vld = 1'b1;
      end
      cls_out_vld = (ret_q.size() > 0);
      if (ret_q.size() > 0) cls_out = ret_q[0];
      cls_in_rdy = ($urandom % 4) != 0;
    end
  end

  initial begin : host_sink
    cxp_out_rdy = 1'b0;
    forever begin
      @(posedge mlx2sbu_clk);
      #1 cxp_out_rdy = rst_n && (($urandom % 3) != 0);
    end
  end

  // all outputs sampled mid cycle
  initial begin : scoreboard
    fw_stream_pkg::beat_t exp_beat;
    logic                 prev_rst;
    logic                 first_out;
    int                   data_cnt;
    int                   verd_cnt;
    in_idx          = 0;
    out_idx         = 0;
    verdicts_pulsed = 0;
    wd_edges        = 0;
    prev_rst        = 1'b0;
    data_cnt        = 0;
    verd_cnt        = 0;
    forever begin
      @(negedge mlx2sbu_clk);
      if (prev_rst) wd_edges++;   // edges that saw reset released
      prev_rst = rst_n;
      if (rst_n) begin
        first_out = (out_idx < out_q.size()) &&
                    (out_idx == 0 || out_pkt[out_idx-1] != out_pkt[out_idx]);
        check_bit("watchdog", watchdog, 1'((wd_edges / `FW_WDOG_HALF) % 2));
        check_bit("nwp_in_rdy", nwp_in_rdy, cls_in_rdy);
        check_bit("cls_in_vld", cls_in_vld, nwp_in_vld);
        check_bit("tuple_req", tuple_req, nwp_in_vld && cls_in_rdy && src_q[in_idx].tlast);
        check_bit("cls_out_rdy", cls_out_rdy, data_cnt < `FW_DATA_DEPTH);
        check_bit("verdict_rdy", verdict_rdy, verd_cnt < `FW_VERDICT_DEPTH);
        // first beat of a packet only with a verdict queued
        check_bit("cxp_out_vld", cxp_out_vld, data_cnt > 0 && (!first_out || verd_cnt > 0));
        if (cls_in_vld && cls_in_rdy) begin
          exp_beat       = src_q[in_idx];
          exp_beat.tdata = {<<8{src_q[in_idx].tdata}};
          exp_beat.tkeep = {<<{src_q[in_idx].tkeep}};
          check_beat("cls_in", cls_in, exp_beat);
          in_idx++;
        end
        if (cls_out_vld && cls_out_rdy) data_cnt++;
        if (verdict_vld && verdict_rdy) verd_cnt++;
        if (verdict_vld) verdicts_pulsed++;
        if (cxp_out_vld && cxp_out_rdy) begin
          if (out_idx >= out_q.size()) begin
            $display("more beats on cxp_out than were sent in");
            stop_with_failure();
          end
          check_bit("verdict pulsed before beat", verdicts_pulsed > out_pkt[out_idx], 1'b1);
          check_beat("cxp_out", cxp_out, out_q[out_idx]);
          data_cnt--;
          if (first_out) verd_cnt--;
          out_idx++;
        end
      end
    end
  end

  initial begin : timeout_guard
    int cycles;
    int limit;
    cycles = 0;
    limit  = 20 * total_beats() + 4 * `FW_WDOG_HALF;
    forever begin
      @(posedge mlx2sbu_clk);
      cycles++;
      if (cycles > limit) begin
        $display("timeout: run still busy after %0d cycles", limit);
        stop_with_failure();
      end
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/fw_stream_pkg.sv
rtl/fw_shell_pkg.sv
rtl/classify_decode.sv
rtl/frame_fifo.sv
rtl/verdict_merge.sv
rtl/shell_watchdog.sv
rtl/fw_top.sv
testbench/fw_assert.sv
testbench/fw_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the firewall testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fw_tb \
  -f vlog.f -o fw_sim \
  && ./obj_dir/fw_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^All tests passed$" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
